//--- verilog/marble_pkg.sv
package marble_pkg;

	// Local bus geometry
	localparam int LB_AW = 4;  // Word address width
	localparam int LB_DW = 32; // Data width

	// Register map
	localparam logic [LB_AW-1:0] ADDR_CONFIG  = LB_AW'(0); // Board configuration word
	localparam logic [LB_AW-1:0] ADDR_SCRATCH = LB_AW'(1); // Free read/write word
	localparam logic [LB_AW-1:0] ADDR_FRAMES  = LB_AW'(2); // Transmitted frame count
	localparam logic [LB_AW-1:0] ADDR_ID      = LB_AW'(3); // Fixed identification

	// Identification word, "MRBL" in ASCII
	localparam logic [LB_DW-1:0] BOARD_ID = 32'h4d52_424c;

	// Ethernet framing
	localparam int PREAMBLE_LEN = 7;                  // Bytes of 0x55 before the SFD
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE = 8'hd5;          // Start-of-frame delimiter
	localparam int IFG_LEN = 12;                      // Minimum idle cycles between frames

	// Configuration word
	// Written by the bus as one raw word, decoded by the board as fields
	typedef union packed {
		logic [LB_DW-1:0] raw;
		struct packed {
			logic [LB_DW-12:0] reserved; // Read back as written
			logic tx_disable;            // Bit 10, holds off new frames
			logic phy_reset;             // Bit 9, drives PHY reset low
			logic vcxo_off;              // Bit 8, turns off the 20 MHz VCXO
			logic [7:0] led;             // Bits 7..0, direct LED pattern
		} f;
	} board_config_u;

endpackage

//--- verilog/gmii_tx_framer.sv
module gmii_tx_framer (
	input  logic       tx_clk,
	input  logic       rst_n,
	input  logic       tx_enable,  // From the config word, gates frame start only
	input  logic [7:0] s_data,
	input  logic       s_valid,
	input  logic       s_last,
	output logic       s_ready,
	output logic [7:0] gmii_txd,
	output logic       gmii_tx_en,
	output logic       gmii_tx_er,
	output logic       frame_done // One cycle, with the last byte on GMII
);

	// State names what GMII carries in the current cycle
	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_PRE  = 3'd1;
	localparam logic [2:0] ST_SFD  = 3'd2;
	localparam logic [2:0] ST_DATA = 3'd3;
	localparam logic [2:0] ST_GAP  = 3'd4;

	// One counter serves both preamble and gap
	localparam int CNT_W = $clog2(marble_pkg::IFG_LEN + 1);

	logic [2:0] state;
	logic [CNT_W-1:0] cnt;

	// Payload is taken from the SFD cycle until s_last goes through
	assign s_ready = (state == ST_SFD) || (state == ST_DATA);

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			cnt <= '0;
			gmii_txd <= '0;
			gmii_tx_en <= 1'b0;
			gmii_tx_er <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			gmii_tx_er <= 1'b0; // Raised only on an underrun
			frame_done <= 1'b0;
			case (state)
				ST_IDLE: begin
					gmii_txd <= '0;
					gmii_tx_en <= 1'b0;
					if (tx_enable && s_valid) begin // Pending data starts a frame
						gmii_txd <= marble_pkg::PREAMBLE_BYTE;
						gmii_tx_en <= 1'b1;
						cnt <= CNT_W'(1); // First preamble byte goes out now
						state <= ST_PRE;
					end
				end
				ST_PRE: begin
					gmii_tx_en <= 1'b1;
					if (cnt == CNT_W'(marble_pkg::PREAMBLE_LEN)) begin
						gmii_txd <= marble_pkg::SFD_BYTE;
						state <= ST_SFD;
					end else begin
						gmii_txd <= marble_pkg::PREAMBLE_BYTE;
						cnt <= cnt + 1'b1;
					end
				end
				ST_SFD, ST_DATA: begin
					gmii_tx_en <= 1'b1;
					state <= ST_DATA;
					if (s_valid) begin
						gmii_txd <= s_data; // Accepted byte, one cycle later on GMII
						if (s_last) begin
							frame_done <= 1'b1;
							cnt <= '0;
							state <= ST_GAP;
						end
					end else begin
						// Stream stalled inside the frame
						gmii_txd <= 8'h00;
						gmii_tx_er <= 1'b1;
					end
				end
				ST_GAP: begin
					gmii_txd <= '0;
					gmii_tx_en <= 1'b0;
					if (cnt == CNT_W'(marble_pkg::IFG_LEN - 1))
						state <= ST_IDLE; // Last idle cycle of the gap shows in IDLE
					else
						cnt <= cnt + 1'b1;
				end
				default: begin
					gmii_txd <= '0;
					gmii_tx_en <= 1'b0;
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Error is only meaningful inside a frame, and carries a zero byte
	a_er_inside_frame: assert property (@(posedge tx_clk) disable iff (!rst_n)
		gmii_tx_er |-> (gmii_tx_en && gmii_txd == 8'h00));

	// From the last byte through the whole gap the stream is held off
	a_no_ready_in_gap: assert property (@(posedge tx_clk) disable iff (!rst_n)
		frame_done |-> !s_ready [*(marble_pkg::IFG_LEN + 1)]);

	// Gap keeps the line idle after every frame
	a_gap_idle: assert property (@(posedge tx_clk) disable iff (!rst_n)
		frame_done |=> !gmii_tx_en [*marble_pkg::IFG_LEN]);

endmodule

//--- verilog/gmii_to_rgmii_tx.sv
module gmii_to_rgmii_tx (
	input  logic       tx_clk,
	input  logic       rst_n,
	input  logic [7:0] gmii_txd,
	input  logic       gmii_tx_en,
	input  logic       gmii_tx_er,
	output logic [3:0] rgmii_txd_rise, // Low nibble in the first half of the clock
	output logic [3:0] rgmii_txd_fall, // High nibble in the second half
	output logic       rgmii_ctl_rise,
	output logic       rgmii_ctl_fall
);

	// Fabric side of the DDR stage
	// On hardware each rise/fall pair feeds one ODDR D1/D2
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			rgmii_txd_rise <= '0;
			rgmii_txd_fall <= '0;
			rgmii_ctl_rise <= 1'b0;
			rgmii_ctl_fall <= 1'b0;
		end else begin
			rgmii_txd_rise <= gmii_txd[3:0];
			rgmii_txd_fall <= gmii_txd[7:4];
			rgmii_ctl_rise <= gmii_tx_en;              // TX_CTL rising half is TX_EN
			rgmii_ctl_fall <= gmii_tx_en ^ gmii_tx_er; // Falling half is EN xor ER
		end
	end

endmodule

//--- verilog/lb_config_regs.sv
module lb_config_regs #(
	parameter logic [marble_pkg::LB_DW-1:0] config_default = '0 // Config word after reset
) (
	input  logic                          tx_clk,
	input  logic                          rst_n,
	input  logic [marble_pkg::LB_AW-1:0]  lb_addr,
	input  logic [marble_pkg::LB_DW-1:0]  lb_data_out, // Bus to register
	input  logic                          lb_strobe,
	input  logic                          lb_write,
	input  logic                          lb_rd,
	input  logic                          frame_done,
	output logic [marble_pkg::LB_DW-1:0]  lb_data_in,  // Register to bus
	output logic                          lb_rd_valid,
	output logic [7:0]                    led,
	output logic                          vcxo_en,
	output logic                          phy_rstn,
	output logic                          tx_enable
);

	marble_pkg::board_config_u cfg;
	logic [marble_pkg::LB_DW-1:0] scratch;
	logic [marble_pkg::LB_DW-1:0] frame_cnt;

	wire wr_stb = lb_strobe && lb_write;
	wire rd_stb = lb_strobe && lb_rd;

	// Write decode
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			cfg.raw <= config_default;
			scratch <= '0;
		end else if (wr_stb) begin
			case (lb_addr)
				marble_pkg::ADDR_CONFIG:  cfg.raw <= lb_data_out; // Whole word, fields decode below
				marble_pkg::ADDR_SCRATCH: scratch <= lb_data_out;
				default: ;                // Frames and ID are read only
			endcase
		end
	end

	// Frames sent since reset, wraps
	always_ff @(posedge tx_clk) begin
		if (!rst_n)
			frame_cnt <= '0;
		else if (frame_done)
			frame_cnt <= frame_cnt + 1'b1;
	end

	// Read return, one cycle after the strobe
	always_ff @(posedge tx_clk) begin
		if (!rst_n)
			lb_rd_valid <= 1'b0;
		else
			lb_rd_valid <= rd_stb;
	end

	always_ff @(posedge tx_clk) begin
		if (rd_stb) begin
			case (lb_addr)
				marble_pkg::ADDR_CONFIG:  lb_data_in <= cfg.raw;
				marble_pkg::ADDR_SCRATCH: lb_data_in <= scratch;
				marble_pkg::ADDR_FRAMES:  lb_data_in <= frame_cnt;
				marble_pkg::ADDR_ID:      lb_data_in <= marble_pkg::BOARD_ID;
				default:                  lb_data_in <= '0; // Unmapped reads as zero
			endcase
		end
	end

	// Board controls straight from the fields, all active high "off" bits
	assign led = cfg.f.led;
	assign vcxo_en = ~cfg.f.vcxo_off;
	assign phy_rstn = ~cfg.f.phy_reset;
	assign tx_enable = ~cfg.f.tx_disable;

	// Every read strobe gets exactly one valid, one cycle later
	a_rd_valid_follows: assert property (@(posedge tx_clk) disable iff (!rst_n)
		rd_stb |=> lb_rd_valid);
	a_rd_valid_cause: assert property (@(posedge tx_clk) disable iff (!rst_n)
		lb_rd_valid |-> $past(rd_stb));

endmodule

//--- verilog/board_top.sv
module board_top #(
	parameter logic [marble_pkg::LB_DW-1:0] config_default = 32'h0000_0001 // LED 0 lit
) (
	input  logic                          tx_clk,
	input  logic                          rst_n,

	// Transmit byte stream
	input  logic [7:0]                    s_data,
	input  logic                          s_valid,
	input  logic                          s_last,
	output logic                          s_ready,

	// Local bus
	input  logic [marble_pkg::LB_AW-1:0]  lb_addr,
	input  logic [marble_pkg::LB_DW-1:0]  lb_data_out,
	input  logic                          lb_strobe,
	input  logic                          lb_write,
	input  logic                          lb_rd,
	output logic [marble_pkg::LB_DW-1:0]  lb_data_in,
	output logic                          lb_rd_valid,

	// RGMII transmit, both halves of each DDR pin
	output logic [3:0]                    rgmii_txd_rise,
	output logic [3:0]                    rgmii_txd_fall,
	output logic                          rgmii_ctl_rise,
	output logic                          rgmii_ctl_fall,

	// Board controls
	output logic [7:0]                    led,
	output logic                          vcxo_en,
	output logic                          phy_rstn
);

	logic [7:0] gmii_txd;
	logic gmii_tx_en;
	logic gmii_tx_er;
	logic frame_done; // Framer to frame counter
	logic tx_enable;  // Config bit to framer

	gmii_tx_framer i_framer (
		.tx_clk     (tx_clk),
		.rst_n      (rst_n),
		.tx_enable  (tx_enable),
		.s_data     (s_data),
		.s_valid    (s_valid),
		.s_last     (s_last),
		.s_ready    (s_ready),
		.gmii_txd   (gmii_txd),
		.gmii_tx_en (gmii_tx_en),
		.gmii_tx_er (gmii_tx_er),
		.frame_done (frame_done)
	);

	// GMII to the pin-side nibbles, one more register stage
	gmii_to_rgmii_tx i_rgmii (
		.tx_clk         (tx_clk),
		.rst_n          (rst_n),
		.gmii_txd       (gmii_txd),
		.gmii_tx_en     (gmii_tx_en),
		.gmii_tx_er     (gmii_tx_er),
		.rgmii_txd_rise (rgmii_txd_rise),
		.rgmii_txd_fall (rgmii_txd_fall),
		.rgmii_ctl_rise (rgmii_ctl_rise),
		.rgmii_ctl_fall (rgmii_ctl_fall)
	);

	lb_config_regs #(
		.config_default (config_default)
	) i_regs (
		.tx_clk      (tx_clk),
		.rst_n       (rst_n),
		.lb_addr     (lb_addr),
		.lb_data_out (lb_data_out),
		.lb_strobe   (lb_strobe),
		.lb_write    (lb_write),
		.lb_rd       (lb_rd),
		.frame_done  (frame_done),
		.lb_data_in  (lb_data_in),
		.lb_rd_valid (lb_rd_valid),
		.led         (led),
		.vcxo_en     (vcxo_en),
		.phy_rstn    (phy_rstn),
		.tx_enable   (tx_enable)
	);

endmodule

//--- tests/board_top_checks.sv
module board_top_checks (
	input  logic       tx_clk,
	input  logic       rst_n,
	input  logic [7:0] s_data,
	input  logic       s_valid,
	input  logic       s_last,
	input  logic       s_ready,
	input  logic [3:0] rgmii_txd_rise,
	input  logic [3:0] rgmii_txd_fall,
	input  logic       rgmii_ctl_rise,
	input  logic       rgmii_ctl_fall,
	input  logic       lb_strobe,
	input  logic       lb_rd,
	input  logic       lb_rd_valid,
	input  logic       hold_off, // High while a frame is held back by tx_disable
	output logic       all_seen  // Every accepted byte came out on RGMII
);
	timeunit 1ns;
	timeprecision 100ps;

	event mismatch; // Watched by the testbench top

	// Bytes taken by the framer, in order, with their s_last flag
	logic [7:0] sent_mem [0:1023];
	logic       sent_last [0:1023];
	logic [9:0] wr_ptr;
	logic [9:0] rd_ptr;
	logic [15:0] pos;   // Byte index inside the current RGMII frame
	logic [7:0] gap_cnt; // Idle cycles since the last frame
	logic prev_last;     // Last payload byte carried s_last

	wire [7:0] rx_byte = {rgmii_txd_fall, rgmii_txd_rise}; // Low nibble goes out first
	wire payload = rgmii_ctl_rise && rgmii_ctl_fall && (pos > 16'd7);

	assign all_seen = (rd_ptr == wr_ptr);

	task automatic report(input string msg);
		$display("%s", msg);
		-> mismatch;
	endtask

	// Stream side, one entry per handshake
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (s_valid && s_ready) begin
			sent_mem[wr_ptr] <= s_data;
			sent_last[wr_ptr] <= s_last;
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// RGMII decoder
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			pos <= '0;
			gap_cnt <= 8'(marble_pkg::IFG_LEN); // First frame needs no gap
			prev_last <= 1'b0;
		end else begin
			pos <= rgmii_ctl_rise ? pos + 1'b1 : '0;
			if (rgmii_ctl_rise)
				gap_cnt <= '0;
			else if (gap_cnt != 8'hff)
				gap_cnt <= gap_cnt + 1'b1; // Saturates on long idle
			if (payload) begin
				rd_ptr <= rd_ptr + 1'b1;
				prev_last <= sent_last[rd_ptr];
			end else if (rgmii_ctl_rise && pos == 16'd0) begin
				prev_last <= 1'b0; // New frame
			end
		end
	end

	a_preamble: assert property (@(posedge tx_clk) disable iff (!rst_n)
		(rgmii_ctl_rise && pos < 16'd7) |-> (rgmii_ctl_fall && rx_byte == 8'h55))
		else report($sformatf("Error: preamble rx_byte = %h, expected 55", $sampled(rx_byte)));

	a_sfd: assert property (@(posedge tx_clk) disable iff (!rst_n)
		(rgmii_ctl_rise && pos == 16'd7) |-> (rgmii_ctl_fall && rx_byte == 8'hd5))
		else report($sformatf("Error: delimiter rx_byte = %h, expected d5", $sampled(rx_byte)));

	// Payload in order, nothing invented
	a_payload: assert property (@(posedge tx_clk) disable iff (!rst_n)
		payload |-> (rd_ptr != wr_ptr && rx_byte == sent_mem[rd_ptr]))
		else report($sformatf("Error: payload rx_byte = %h, expected %h",
			$sampled(rx_byte), sent_mem[$sampled(rd_ptr)]));

	// Underrun is a zero byte inside the payload
	a_underrun_where: assert property (@(posedge tx_clk) disable iff (!rst_n)
		(rgmii_ctl_rise && !rgmii_ctl_fall) |-> (pos > 16'd7 && rx_byte == 8'h00))
		else report($sformatf("Error: underrun rx_byte = %h at pos = %h, expected 00",
			$sampled(rx_byte), $sampled(pos)));

	a_underrun_cause: assert property (@(posedge tx_clk) disable iff (!rst_n)
		$past(s_ready && !s_valid, 2) |-> (rgmii_ctl_rise && !rgmii_ctl_fall))
		else report("Stream stall did not show up as an RGMII error cycle");

	a_frame_end: assert property (@(posedge tx_clk) disable iff (!rst_n)
		$fell(rgmii_ctl_rise) |-> prev_last)
		else report("RGMII frame ended before the byte marked with s_last");

	a_gap: assert property (@(posedge tx_clk) disable iff (!rst_n)
		$rose(rgmii_ctl_rise) |-> (gap_cnt >= 8'(marble_pkg::IFG_LEN)))
		else report($sformatf("Error: gap_cnt = %h before frame, expected at least %h",
			$sampled(gap_cnt), marble_pkg::IFG_LEN));

	// Ready only while the delimiter or payload is on GMII
	a_ready_window: assert property (@(posedge tx_clk) disable iff (!rst_n)
		s_ready |=> (rgmii_ctl_rise && pos >= 16'd7))
		else report("s_ready was high outside the delimiter and payload cycles");

	a_stable: assert property (@(posedge tx_clk) disable iff (!rst_n)
		(s_valid && !s_ready) |=> (s_valid && $stable(s_data) && $stable(s_last)))
		else report("Stream changed while s_ready was low");

	a_hold_off: assert property (@(posedge tx_clk) disable iff (!rst_n)
		hold_off |-> !rgmii_ctl_rise)
		else report("Frame started on RGMII while tx_disable was set");

	a_rd_valid: assert property (@(posedge tx_clk) disable iff (!rst_n)
		(lb_strobe && lb_rd) |=> lb_rd_valid)
		else report("lb_rd_valid missing one cycle after a read strobe");

	a_rd_cause: assert property (@(posedge tx_clk) disable iff (!rst_n)
		lb_rd_valid |-> $past(lb_strobe && lb_rd))
		else report("lb_rd_valid without a read strobe one cycle before");

endmodule

//--- tests/board_top_tb.sv
module board_top_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_FRAMES = 6;
	localparam int WATCHDOG_CYCLES = 200 * NUM_FRAMES + 500;
	localparam logic [31:0] CONFIG_DEFAULT = 32'h0000_00a5; // LEDs a5, control bits clear

	logic tx_clk = 1'b0;
	logic rst_n;
	logic [7:0] s_data;
	logic s_valid;
	logic s_last;
	logic s_ready;
	logic [marble_pkg::LB_AW-1:0] lb_addr;
	logic [31:0] lb_data_out;
	logic lb_strobe;
	logic lb_write;
	logic lb_rd;
	logic [31:0] lb_data_in;
	logic lb_rd_valid;
	logic [3:0] rgmii_txd_rise;
	logic [3:0] rgmii_txd_fall;
	logic rgmii_ctl_rise;
	logic rgmii_ctl_fall;
	logic [7:0] led;
	logic vcxo_en;
	logic phy_rstn;
	logic hold_off;
	logic all_seen;

	integer seed = 32'h8134ac59;
	logic [7:0] frame_q [$]; // Payload of the frame being sent
	logic [31:0] rd_data;
	logic [31:0] scratch_val;
	int frames_sent;

	always #10 tx_clk = ~tx_clk; // 20 ns period

	board_top #(.config_default(CONFIG_DEFAULT)) i_dut (.*);

	board_top_checks i_chk (.*);

	task automatic abort_run(input string why);
		$display("Test failed");
		$fatal(1, "%s", why);
	endtask

	task automatic expect_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp)
		else begin
			$display("Error: %s = %h, expected %h", name, got, exp);
			abort_run("value mismatch");
		end
	endtask

	// Inputs move 2 ns after the edge
	task automatic step();
		@(posedge tx_clk);
		#2;
	endtask

	task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
		lb_addr = addr;
		lb_data_out = data;
		lb_strobe = 1'b1;
		lb_write = 1'b1;
		step();
		lb_strobe = 1'b0;
		lb_write = 1'b0;
	endtask

	task automatic bus_read(input logic [3:0] addr, output logic [31:0] data);
		lb_addr = addr;
		lb_strobe = 1'b1;
		lb_rd = 1'b1;
		step();
		lb_strobe = 1'b0;
		lb_rd = 1'b0;
		data = lb_data_in; // Valid in the cycle after the strobe
	endtask

	task automatic make_frame(input int len);
		frame_q.delete();
		repeat (len) frame_q.push_back(8'($random(seed)));
	endtask

	// Gaps drop s_valid between bytes, stall_at adds a fixed 3-cycle stall
	task automatic send_frame(input bit gaps, input int stall_at);
		int n;
		int len;
		len = frame_q.size();
		for (n = 0; n < len; n++) begin
			s_valid = 1'b1;
			s_data = frame_q[n];
			s_last = (n == len - 1);
			while (!s_ready)
				step(); // Held stable through preamble or gap
			step(); // Byte goes through on this edge
			s_valid = 1'b0;
			s_last = 1'b0;
			if (n == stall_at)
				repeat (3) step();
			else if (gaps && n != len - 1 && ($random(seed) & 3) == 0)
				repeat (1 + ($random(seed) & 1)) step();
		end
		frames_sent++;
	endtask

	task automatic wait_idle();
		repeat (3) step(); // Last byte reaches RGMII two cycles after acceptance
		while (rgmii_ctl_rise)
			step();
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge tx_clk);
		abort_run("watchdog expired before the tests finished");
	end

	initial begin
		@(i_chk.mismatch);
		abort_run("checker assertion fired");
	end

	initial begin
		rst_n = 1'b0;
		s_data = '0;
		s_valid = 1'b0;
		s_last = 1'b0;
		lb_addr = '0;
		lb_data_out = '0;
		lb_strobe = 1'b0;
		lb_write = 1'b0;
		lb_rd = 1'b0;
		hold_off = 1'b0;
		frames_sent = 0;
		repeat (10) @(posedge tx_clk);
		#2;
		// Still in reset here
		expect_value("s_ready", s_ready, 0);
		expect_value("gmii_tx_en", i_dut.i_framer.gmii_tx_en, 0);
		expect_value("gmii_tx_er", i_dut.i_framer.gmii_tx_er, 0);
		expect_value("frame_done", i_dut.i_framer.frame_done, 0);
		expect_value("lb_rd_valid", lb_rd_valid, 0);
		expect_value("rgmii", {rgmii_txd_fall, rgmii_txd_rise, rgmii_ctl_rise, rgmii_ctl_fall}, 0);
		expect_value("led", led, 8'ha5);
		expect_value("vcxo_en", vcxo_en, 1);
		expect_value("phy_rstn", phy_rstn, 1);
		rst_n = 1'b1;
		step();

		bus_read(marble_pkg::ADDR_CONFIG, rd_data);
		expect_value("config", rd_data, CONFIG_DEFAULT);
		bus_read(marble_pkg::ADDR_SCRATCH, rd_data);
		expect_value("scratch", rd_data, 0);
		bus_read(marble_pkg::ADDR_FRAMES, rd_data);
		expect_value("frames", rd_data, 0);
		scratch_val = $random(seed);
		bus_write(marble_pkg::ADDR_SCRATCH, scratch_val);
		bus_read(marble_pkg::ADDR_SCRATCH, rd_data);
		expect_value("scratch", rd_data, scratch_val);
		bus_read(marble_pkg::ADDR_ID, rd_data);
		expect_value("id", rd_data, marble_pkg::BOARD_ID);

		make_frame(16);
		send_frame(1'b0, -1);
		make_frame(24);
		send_frame(1'b1, 5); // Deliberate mid-frame stall
		repeat (2) begin
			make_frame(8 + ($random(seed) & 31));
			send_frame(1'b1, -1);
		end
		wait_idle();

		bus_write(marble_pkg::ADDR_CONFIG, 32'h0000_033c); // vcxo_off and phy_reset
		expect_value("led", led, 8'h3c);
		expect_value("vcxo_en", vcxo_en, 0);
		expect_value("phy_rstn", phy_rstn, 0);
		bus_write(marble_pkg::ADDR_CONFIG, 32'h0000_04c3); // tx_disable only
		expect_value("led", led, 8'hc3);
		expect_value("vcxo_en", vcxo_en, 1);
		expect_value("phy_rstn", phy_rstn, 1);

		// Frame waits with s_valid up until tx_disable clears
		make_frame(12);
		s_valid = 1'b1;
		s_data = frame_q[0];
		s_last = 1'b0;
		hold_off = 1'b1;
		repeat (40) step();
		hold_off = 1'b0;
		bus_write(marble_pkg::ADDR_CONFIG, CONFIG_DEFAULT);
		send_frame(1'b1, -1);
		make_frame(20);
		send_frame(1'b1, 9);
		wait_idle();

		bus_read(marble_pkg::ADDR_FRAMES, rd_data);
		expect_value("frames", rd_data, frames_sent);
		expect_value("all_seen", all_seen, 1);
		$display("Test passed");
		$finish;
	end

endmodule

//--- board_top.f
verilog/marble_pkg.sv
verilog/gmii_tx_framer.sv
verilog/gmii_to_rgmii_tx.sv
verilog/lb_config_regs.sv
verilog/board_top.sv
tests/board_top_checks.sv
tests/board_top_tb.sv

//--- Makefile
# Verilator build and run for board_top

VERILATOR ?= verilator
TOP       ?= board_top_tb
RTL_TOP   ?= board_top
FILELIST  ?= board_top.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) \
		--top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
